// File: water_pkg.sv
// Shared types and constants for the boiler temperature controller
// Temperatures are arbitrary units 0..255, not degrees
// Rate constants are scaled to tens of cycles so simulations stay short
// This is a behavioural model of the boiler and does not run in real time
// Setpoints top out at 230, so no overheat handling exists

package water_pkg;

    // ========================================
    // Types
    // ========================================
    typedef logic [7:0] temp_t;

    typedef enum logic [1:0] {
        STANDBY   = 2'd0,                 // Warm hold
        BREW      = 2'd1,                 // Normal brew
        EXTRA_HOT = 2'd2,
        RESERVED  = 2'd3                  // Treated as brew
    } temp_mode_e;

    typedef enum logic [1:0] {
        COLD    = 2'd0,
        HEATING = 2'd1,
        AT_TEMP = 2'd2,
        COOLING = 2'd3
    } heat_state_e;

    // Levels from the brew sequencer
    typedef struct packed {
        logic       heating_enable;
        logic       brewing_active;
        temp_mode_e mode;
    } water_ctrl_t;

    typedef struct packed {
        logic  heater_enable;
        logic  temp_ready;
        logic  pressure_ready;
        logic  system_ok;
        temp_t current_temp;              // Modelled water temp
        temp_t target_temp;               // Active setpoint
    } water_status_t;

    // ========================================
    // Setpoints and band
    // ========================================
    localparam temp_t TEMP_COLD      = 8'd25;   // Room temp, cooling floor
    localparam temp_t TEMP_STANDBY   = 8'd150;
    localparam temp_t TEMP_BREW      = 8'd200;
    localparam temp_t TEMP_EXTRA_HOT = 8'd230;
    localparam temp_t TEMP_BAND      = 8'd5;    // Half-width of ready band
    localparam temp_t COLD_MARGIN    = 8'd10;   // Cooling counts as cold below floor + this

    // ========================================
    // Rates
    // ========================================
    localparam int BASE_TICK_CYCLES      = 8;
    localparam int HEAT_DIV              = 2;   // Base ticks per heat step
    localparam int COOL_DIV              = 6;   // Base ticks per cool step
    localparam int PRESSURE_CHECK_CYCLES = 32;

    // Counter widths derived from the rates
    localparam int BASE_CNT_W  = $clog2(BASE_TICK_CYCLES);
    localparam int HEAT_DIV_W  = $clog2(HEAT_DIV);
    localparam int COOL_DIV_W  = $clog2(COOL_DIV);
    localparam int PRESS_CNT_W = $clog2(PRESSURE_CHECK_CYCLES);

endpackage

// File: rate_tick_gen.sv
// Base update tick plus divided heat and cool strobes
// heat_step pulses every 16 cycles, cool_step every 48 cycles
// Strobes are single-cycle and never both start right out of reset

`timescale 1ns/1ns

module rate_tick_gen (
    input  logic clk,
    input  logic rst_n,
    output logic heat_step,
    output logic cool_step
);
    import water_pkg::*;

    logic [BASE_CNT_W-1:0] base_cnt;
    logic                  base_tick;
    logic [HEAT_DIV_W-1:0] heat_div;
    logic [COOL_DIV_W-1:0] cool_div;

    // Base counter, one tick per BASE_TICK_CYCLES
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_cnt  <= '0;
            base_tick <= 1'b0;
        end else if (base_cnt == BASE_CNT_W'(BASE_TICK_CYCLES - 1)) begin
            base_cnt  <= '0;
            base_tick <= 1'b1;
        end else begin
            base_cnt  <= base_cnt + 1'b1;
            base_tick <= 1'b0;
        end
    end

    // Heat and cool dividers advance on base ticks only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            heat_div  <= '0;
            cool_div  <= '0;
            heat_step <= 1'b0;
            cool_step <= 1'b0;
        end else begin
            heat_step <= base_tick && (heat_div == HEAT_DIV_W'(HEAT_DIV - 1));
            cool_step <= base_tick && (cool_div == COOL_DIV_W'(COOL_DIV - 1));
            if (base_tick) begin
                heat_div <= (heat_div == HEAT_DIV_W'(HEAT_DIV - 1)) ? '0 : heat_div + 1'b1;
                cool_div <= (cool_div == COOL_DIV_W'(COOL_DIV - 1)) ? '0 : cool_div + 1'b1;
            end
        end
    end

    // No strobe may leak out in the first cycle after reset
    a_no_step_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !(heat_step || cool_step));

endmodule

// File: setpoint_compare.sv
// Setpoint register and hysteresis band compare
// target_temp follows the mode one cycle later
// Band flags are combinational from current_temp and the registered setpoint
// Setpoints are between 150 and 230, so the band never wraps

`timescale 1ns/1ns

module setpoint_compare (
    input  logic                 clk,
    input  logic                 rst_n,
    input  water_pkg::temp_mode_e mode,
    input  water_pkg::temp_t     current_temp,
    output water_pkg::temp_t     target_temp,
    output logic                 below,
    output logic                 at_target,
    output logic                 above
);
    import water_pkg::*;

    temp_t band_lo;
    temp_t band_hi;

    // Mode to setpoint
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            target_temp <= TEMP_STANDBY;
        end else begin
            case (mode)
                STANDBY:   target_temp <= TEMP_STANDBY;
                BREW:      target_temp <= TEMP_BREW;
                EXTRA_HOT: target_temp <= TEMP_EXTRA_HOT;
                default:   target_temp <= TEMP_BREW;     // RESERVED runs as brew
            endcase
        end
    end

    assign band_lo = target_temp - TEMP_BAND;
    assign band_hi = target_temp + TEMP_BAND;

    // Inclusive band
    assign at_target = (current_temp >= band_lo) && (current_temp <= band_hi);
    assign below     = current_temp < band_lo;
    assign above     = current_temp > band_hi;

    a_band_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot({below, at_target, above}));

endmodule

// File: heater_fsm.sv
// Heater state machine, COLD / HEATING / AT_TEMP / COOLING
// Outputs are registered and change one cycle after their cause
// temp_ready is only ever high in HEATING on exit or in AT_TEMP
// Band flags come from setpoint_compare, current_temp only for the cold test

`timescale 1ns/1ns

module heater_fsm (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             heating_enable,
    input  logic             brewing_active,
    input  logic             below,
    input  logic             at_target,
    input  logic             above,
    input  water_pkg::temp_t current_temp,
    output logic             heater_enable,
    output logic             temp_ready
);
    import water_pkg::*;

    heat_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= COLD;
            heater_enable <= 1'b0;
            temp_ready    <= 1'b0;
        end else begin
            case (state)
                COLD: begin
                    temp_ready <= 1'b0;
                    if (heating_enable) begin
                        state         <= HEATING;
                        heater_enable <= 1'b1;     // Start heating right away
                    end else begin
                        heater_enable <= 1'b0;
                    end
                end

                HEATING: begin
                    if (!heating_enable) begin
                        state         <= COOLING;
                        heater_enable <= 1'b0;
                        temp_ready    <= 1'b0;
                    end else if (at_target) begin
                        state         <= AT_TEMP;
                        heater_enable <= 1'b1;     // Hold temp
                        temp_ready    <= 1'b1;
                    end else begin
                        heater_enable <= 1'b1;
                        temp_ready    <= 1'b0;
                    end
                end

                AT_TEMP: begin
                    // Brewing keeps the boiler hot even without enable
                    if (!heating_enable && !brewing_active) begin
                        state         <= COOLING;
                        heater_enable <= 1'b0;
                        temp_ready    <= 1'b0;
                    end else if (below) begin
                        state         <= HEATING;  // Dropped out of band
                        heater_enable <= 1'b1;
                        temp_ready    <= 1'b0;
                    end else if (above) begin
                        heater_enable <= 1'b0;     // Coast down, still usable
                        temp_ready    <= 1'b1;
                    end else begin
                        heater_enable <= 1'b1;
                        temp_ready    <= 1'b1;
                    end
                end

                COOLING: begin
                    temp_ready <= 1'b0;
                    if (heating_enable) begin
                        state         <= HEATING;
                        heater_enable <= 1'b1;
                    end else begin
                        heater_enable <= 1'b0;
                        if (current_temp <= TEMP_COLD + COLD_MARGIN)
                            state <= COLD;
                    end
                end

                default: begin
                    state         <= COLD;
                    heater_enable <= 1'b0;
                    temp_ready    <= 1'b0;
                end
            endcase
        end
    end

    // Ready must never be claimed while cold or cooling down
    a_no_ready_when_cold: assert property (@(posedge clk) disable iff (!rst_n)
        (state == COLD || state == COOLING) |-> !temp_ready);

endmodule

// File: thermal_model.sv
// Behavioural water temperature model, not a physical one
// Rises 1 unit per heat_step while heating and under the setpoint
// Falls 1 unit per cool_step while the heater is off, floor at TEMP_COLD
// Cooling runs three times slower than heating

`timescale 1ns/1ns

module thermal_model (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             heater_enable,
    input  logic             heat_step,
    input  logic             cool_step,
    input  water_pkg::temp_t target_temp,
    output water_pkg::temp_t current_temp
);
    import water_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_temp <= TEMP_COLD;                   // Start at room temp
        end else if (heater_enable) begin
            // Heater never pushes past the setpoint
            if (heat_step && (current_temp < target_temp))
                current_temp <= current_temp + 1'b1;
        end else if (cool_step && (current_temp > TEMP_COLD)) begin
            current_temp <= current_temp - 1'b1;
        end
    end

    // ========================================
    // Checks
    // ========================================

    // Water never cools below the room
    a_temp_floor: assert property (@(posedge clk) disable iff (!rst_n)
        current_temp >= TEMP_COLD);

endmodule

// File: supply_monitor.sv
// Pressure sampling and overall water-system status
// Sensor is sampled once per PRESSURE_CHECK_CYCLES, so changes show within 34 cycles
// pressure_ready resets high, the sensor is trusted until the first sample
// system_ok is combinational from temp_ready and pressure_ready

`timescale 1ns/1ns

module supply_monitor (
    input  logic clk,
    input  logic rst_n,
    input  logic pressure_ok,
    input  logic temp_ready,
    output logic pressure_ready,
    output logic system_ok
);
    import water_pkg::*;

    logic [PRESS_CNT_W-1:0] sample_cnt;
    logic                   sample_strobe;

    // Sample interval counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_cnt    <= '0;
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= (sample_cnt == PRESS_CNT_W'(PRESSURE_CHECK_CYCLES - 1));
            sample_cnt    <= sample_cnt + 1'b1;      // Wraps at the interval
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pressure_ready <= 1'b1;
        else if (sample_strobe)
            pressure_ready <= pressure_ok;           // Hold between samples
    end

    assign system_ok = temp_ready && pressure_ready;

endmodule

// File: water_temp_ctrl.sv
// Boiler controller top level for the drink brewer
// Control inputs are steady levels with no handshake
// Time to ready varies with the start temperature; watch temp_ready rise
// Behavioural model with scaled rates, not suitable as a real-time controller

`timescale 1ns/1ns

module water_temp_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  water_pkg::water_ctrl_t   ctrl,
    input  logic                     pressure_ok,
    output water_pkg::water_status_t status
);
    import water_pkg::*;

    logic  heat_step;
    logic  cool_step;
    logic  below;
    logic  at_target;
    logic  above;
    logic  heater_enable;
    logic  temp_ready;
    logic  pressure_ready;
    logic  system_ok;
    temp_t target_temp;
    temp_t current_temp;

    // ========================================
    // Rate and setpoint
    // ========================================
    rate_tick_gen rate_tick_gen_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .heat_step (heat_step),
        .cool_step (cool_step)
    );

    setpoint_compare setpoint_compare_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mode         (ctrl.mode),
        .current_temp (current_temp),
        .target_temp  (target_temp),
        .below        (below),
        .at_target    (at_target),
        .above        (above)
    );

    // ========================================
    // Heater control and boiler model
    // ========================================
    heater_fsm heater_fsm_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .heating_enable (ctrl.heating_enable),
        .brewing_active (ctrl.brewing_active),
        .below          (below),
        .at_target      (at_target),
        .above          (above),
        .current_temp   (current_temp),
        .heater_enable  (heater_enable),
        .temp_ready     (temp_ready)
    );

    thermal_model thermal_model_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .heater_enable (heater_enable),
        .heat_step     (heat_step),
        .cool_step     (cool_step),
        .target_temp   (target_temp),
        .current_temp  (current_temp)
    );

    supply_monitor supply_monitor_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .pressure_ok    (pressure_ok),
        .temp_ready     (temp_ready),
        .pressure_ready (pressure_ready),
        .system_ok      (system_ok)
    );

    // Status out
    always_comb begin
        status.heater_enable  = heater_enable;
        status.temp_ready     = temp_ready;
        status.pressure_ready = pressure_ready;
        status.system_ok      = system_ok;
        status.current_temp   = current_temp;
        status.target_temp    = target_temp;
    end

endmodule

// File: water_temp_ctrl_tb.sv
// Trace-driven testbench for the boiler controller
// Run from the project root, the trace is read from water_temp_trace.txt
// Inputs change on the rising edge, outputs are sampled on the falling edge
// 40 ns clock, so long waits in the trace are in the thousands of cycles

`timescale 1ns/1ns

module water_temp_ctrl_tb;
    import water_pkg::*;

    typedef enum int {
        WAIT_CYCLES     = 0,
        WAIT_READY_RISE = 1,
        WAIT_READY_FALL = 2,
        WAIT_TEMP       = 3                 // Until current_temp equals arg
    } wait_kind_e;

    // One trace line, fields in file column order
    typedef struct packed {
        int mode;
        int heat_en;
        int brew;
        int press;
        int kind;
        int arg;
        int bound;                          // Cycle limit of the wait
        int hold;                           // temp_ready level during the wait, -1 free
        int exp_heater;                     // Expected values, -1 not checked
        int exp_ready;
        int exp_pready;
        int exp_temp;
        int exp_target;
    } step_t;

    logic          clk = 1'b0;
    logic          rst_n;
    water_ctrl_t   ctrl;
    logic          pressure_ok;
    water_status_t status;

    step_t  steps[$];
    longint watchdog_ns = 0;
    temp_t  prev_temp;
    temp_t  prev_target;
    bit     have_prev = 1'b0;

    water_temp_ctrl water_temp_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .pressure_ok (pressure_ok),
        .status      (status)
    );

    always #20 clk = ~clk;                  // 40 ns period

    // ========================================
    // Reporting and compares
    // ========================================
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_temp(input string name, input temp_t got, input temp_t exp);
        if (got !== exp)
            fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_status(input water_status_t got, input water_status_t exp);
        if (got !== exp)
            fail_run($sformatf("** Error: status = 0x%h, expected 0x%h", got, exp));
    endtask

    // ========================================
    // Trace handling
    // ========================================
    task automatic load_trace();
        int    fd;
        int    n;
        int    f[13];
        string line;
        longint cycles;
        cycles = 3 + 100;                   // Reset plus slack
        fd = $fopen("water_temp_trace.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the trace file water_temp_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                f[7], f[8], f[9], f[10], f[11], f[12]);
                    if (n == 13) begin
                        steps.push_back({f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                         f[7], f[8], f[9], f[10], f[11], f[12]});
                        cycles += f[6] + 1;     // Wait bound plus the apply edge
                    end
                end
            end
            $fclose(fd);
            if (steps.size() == 0)
                fail_run("The trace file holds no test steps");
            watchdog_ns = cycles * 40;
        end
    endtask

    task automatic run_wait(input step_t s);
        wait_kind_e kind;
        int         n;
        bit         done;
        kind = wait_kind_e'(s.kind);
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            @(negedge clk);
            n++;
            if (kind == WAIT_READY_RISE)    // Heater stays on while heating up
                check_bit("heater_enable", status.heater_enable, 1'b1);
            if (s.hold >= 0)
                check_bit("temp_ready", status.temp_ready, s.hold != 0);
            case (kind)
                WAIT_CYCLES:     done = (n >= s.arg);
                WAIT_READY_RISE: done = status.temp_ready;
                WAIT_READY_FALL: done = !status.temp_ready;
                default:         done = (status.current_temp == temp_t'(s.arg));
            endcase
            if (!done && n >= s.bound)
                fail_run($sformatf("A wait of kind %0d did not finish within %0d cycles",
                                   s.kind, s.bound));
        end
    endtask

    task automatic check_step(input step_t s);
        water_status_t exp;
        if (s.exp_heater >= 0 && s.exp_ready >= 0 && s.exp_pready >= 0 &&
            s.exp_temp >= 0 && s.exp_target >= 0) begin
            exp.heater_enable  = (s.exp_heater != 0);
            exp.temp_ready     = (s.exp_ready != 0);
            exp.pressure_ready = (s.exp_pready != 0);
            exp.system_ok      = exp.temp_ready && exp.pressure_ready;
            exp.current_temp   = temp_t'(s.exp_temp);
            exp.target_temp    = temp_t'(s.exp_target);
            check_status(status, exp);
        end else begin
            if (s.exp_heater >= 0)
                check_bit("heater_enable", status.heater_enable, s.exp_heater != 0);
            if (s.exp_ready >= 0)
                check_bit("temp_ready", status.temp_ready, s.exp_ready != 0);
            if (s.exp_pready >= 0)
                check_bit("pressure_ready", status.pressure_ready, s.exp_pready != 0);
            if (s.exp_temp >= 0)
                check_temp("current_temp", status.current_temp, temp_t'(s.exp_temp));
            if (s.exp_target >= 0)
                check_temp("target_temp", status.target_temp, temp_t'(s.exp_target));
        end
    endtask

    // ========================================
    // Watchdog and running checks
    // ========================================
    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        fail_run("Watchdog expired before the trace finished");
    end

    always @(negedge clk) begin
        if (rst_n) begin
            check_bit("system_ok", status.system_ok, status.temp_ready & status.pressure_ready);
            if (status.current_temp < TEMP_COLD)
                fail_run("current_temp dropped below room temperature");
            if (have_prev) begin
                // Heating only ever climbs toward the setpoint
                if (status.current_temp > prev_temp && prev_temp >= prev_target)
                    fail_run("current_temp rose while already at or above target_temp");
                if (status.current_temp != prev_temp &&
                    status.current_temp != prev_temp + 8'd1 &&
                    status.current_temp != prev_temp - 8'd1)
                    fail_run("current_temp changed by more than one unit in a cycle");
            end
            prev_temp   = status.current_temp;
            prev_target = status.target_temp;
            have_prev   = 1'b1;
        end
    end

    // Main sequence
    initial begin
        water_ctrl_t next_ctrl;
        rst_n       <= 1'b0;
        ctrl        <= '0;
        pressure_ok <= 1'b1;
        load_trace();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        foreach (steps[i]) begin
            @(posedge clk);
            next_ctrl.heating_enable = (steps[i].heat_en != 0);
            next_ctrl.brewing_active = (steps[i].brew != 0);
            next_ctrl.mode           = temp_mode_e'(2'(steps[i].mode));
            ctrl        <= next_ctrl;
            pressure_ok <= (steps[i].press != 0);
            run_wait(steps[i]);
            check_step(steps[i]);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: water_temp_trace.txt
# mode heat_en brew press_ok kind arg bound hold | heater ready p_ready temp target
# kind 0 cycles, 1 ready rises, 2 ready falls, 3 temp reaches arg; -1 is not checked
0 0 0 1 0 1 1 -1 0 0 1 25 150
1 0 0 1 0 2 2 -1 0 0 1 25 200
2 0 0 1 0 2 2 -1 0 0 1 25 230
3 0 0 1 0 2 2 -1 0 0 1 25 200
0 0 0 1 0 2 2 -1 0 0 1 25 150
0 1 0 1 1 0 2100 -1 1 1 1 145 150
2 1 0 1 2 0 10 -1 1 0 1 145 230
2 1 0 1 1 0 1500 -1 1 1 1 225 230
0 1 0 1 3 155 3600 1 0 1 1 155 150
0 1 0 1 0 2 2 -1 1 1 1 155 150
0 0 1 1 0 20 20 1 1 1 1 155 150
0 0 1 0 0 34 34 1 1 1 0 155 150
0 0 1 1 0 34 34 1 1 1 1 155 150
0 0 0 1 2 0 10 -1 0 0 1 155 150
0 0 0 1 3 25 6500 -1 0 0 1 25 150
0 0 0 1 0 200 200 -1 0 0 1 25 150

// File: verilog.f
water_pkg.sv
rate_tick_gen.sv
setpoint_compare.sv
heater_fsm.sv
thermal_model.sv
supply_monitor.sv
water_temp_ctrl.sv
water_temp_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the boiler controller testbench with Verilator and run it
# The result is taken from the pass line in the simulator output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module water_temp_ctrl_tb -f verilog.f -o water_temp_ctrl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/water_temp_ctrl_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
